// ==== vlog.f ====
+incdir+src
src/dcache_pkg.sv
src/beat_counter.sv
src/tag_store.sv
src/line_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/axi_mem_model.sv
test/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module dcache_tb -Mdir obj_dir \
    > sim.log 2>&1 && ./obj_dir/Vdcache_tb >> sim.log 2>&1 || echo "build or run error" >> sim.log
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

// ==== test/dcache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20000;   // About 250 operations of up to 60 cycles, plus margin
    localparam int RANDOM_OPS     = 200;

    logic        clock = 1'b0, reset = 1'b1, stall = 1'b0;
    logic        read_enable, write_enable;
    addr_t       address;
    size_t       data_size;
    word_t       data_input, data, m_axi_rdata, m_axi_wdata;
    logic        send_enable;
    logic        m_axi_arready, m_axi_rvalid, m_axi_rlast, m_axi_arvalid, m_axi_rready;
    logic        m_axi_awready, m_axi_wready, m_axi_bvalid, m_axi_awvalid;
    logic        m_axi_wvalid, m_axi_wlast, m_axi_bready;
    addr_t       m_axi_araddr, m_axi_awaddr;
    logic [7:0]  m_axi_arlen, m_axi_awlen, m_axi_wstrb;
    logic [2:0]  m_axi_arsize, m_axi_awsize;
    logic [1:0]  m_axi_arburst, m_axi_awburst, m_axi_bresp;

    logic [7:0]  shadow [4096];
    integer      seed = 38;
    int          errors = 0, tests = 0, cycles = 0, ar_count = 0, aw_count = 0;

    dcache_top dcache_top_i (.*);

    axi_mem_model mem_model_i (
        .clock, .reset, .stall,
        .arvalid(m_axi_arvalid), .araddr(m_axi_araddr), .arlen(m_axi_arlen),
        .arsize(m_axi_arsize), .arburst(m_axi_arburst), .arready(m_axi_arready),
        .rvalid(m_axi_rvalid), .rlast(m_axi_rlast), .rdata(m_axi_rdata), .rready(m_axi_rready),
        .awvalid(m_axi_awvalid), .awaddr(m_axi_awaddr), .awlen(m_axi_awlen),
        .awsize(m_axi_awsize), .awburst(m_axi_awburst), .awready(m_axi_awready),
        .wdata(m_axi_wdata), .wstrb(m_axi_wstrb), .wvalid(m_axi_wvalid), .wlast(m_axi_wlast),
        .wready(m_axi_wready), .bvalid(m_axi_bvalid), .bresp(m_axi_bresp), .bready(m_axi_bready)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (m_axi_arvalid && m_axi_arready) ar_count <= ar_count + 1;
        if (m_axi_awvalid && m_axi_awready) aw_count <= aw_count + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic word_t size_mask(input size_t sz);
        case (sz)
            3'd1:    return 64'hFF;
            3'd2:    return 64'hFFFF;
            3'd4:    return 64'hFFFF_FFFF;
            3'd7:    return '1;
            default: return '0;
        endcase
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        word_t w;
        for (int b = 0; b < 8; b++) w[8*b +: 8] = shadow[{a[11:3], 3'(b)}];
        return w;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return addr_t'((tag << 7) | (set << 6) | (word << 3));
    endfunction

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        errors++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors + mem_model_i.error_count);
    endtask

    task automatic check_idle_outputs();
        assert (!send_enable && !m_axi_arvalid && !m_axi_awvalid && !m_axi_wvalid && !m_axi_rready)
            else begin
                errors++;
                $display("Handshake output high during reset at %0t", $time);
            end
    endtask

    // One CPU access; latency counts the edges up to the send_enable cycle
    task automatic run_op(input logic wr, input addr_t a, input size_t sz, input word_t wd,
                          output int lat, output word_t got);
        @(posedge clock);
        #1;
        read_enable  = !wr;
        write_enable = wr;
        address      = a;
        data_size    = sz;
        data_input   = wd;
        lat = 0;
        @(negedge clock);
        while (!send_enable) begin
            @(negedge clock);
            lat++;
        end
        got = data;
        @(posedge clock);
        #1;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        @(posedge clock);
    endtask

    task automatic check_read(input addr_t a, input size_t sz, output int lat);
        word_t got;
        word_t exp;
        run_op(1'b0, a, sz, '0, lat, got);
        exp = shadow_word(a) & size_mask(sz);
        assert (got === exp) else report_mismatch("data", exp, got);
    endtask

    task automatic do_write(input addr_t a, input size_t sz, input word_t wd);
        int    lat;
        word_t got;
        word_t m;
        run_op(1'b1, a, sz, wd, lat, got);
        m = size_mask(sz);
        for (int b = 0; b < 8; b++) begin
            if (m[8*b]) shadow[{a[11:3], 3'(b)}] = wd[8*b +: 8];
        end
    endtask

    task automatic compare_line(input addr_t a);
        word_t exp;
        for (int i = 0; i < 8; i++) begin
            exp = shadow_word({a[63:6], 3'(i), 3'b0});
            assert (mem_model_i.mem[{a[11:6], 3'(i)}] === exp)
                else report_mismatch("mem_line", exp, mem_model_i.mem[{a[11:6], 3'(i)}]);
        end
    endtask

    initial begin
        int    lat, ar0, aw0, set, tag;
        size_t sizes [5];
        addr_t rand_addr;
        sizes = '{3'd1, 3'd2, 3'd4, 3'd7, 3'd3};
        read_enable  = 1'b0;
        write_enable = 1'b0;
        address      = '0;
        data_size    = '0;
        data_input   = '0;
        for (int i = 0; i < 512; i++) begin
            for (int b = 0; b < 8; b++) begin
                shadow[i*8 + b] = 8'((64'(i*8) ^ 64'h5A5A_5A5A_5A5A_5A5A) >> (8*b));
            end
        end

        repeat (16) begin
            @(negedge clock);
            check_idle_outputs();
        end
        @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        check_idle_outputs();
        finish_test("reset_state");

        ar0 = ar_count;
        check_read(make_addr(1, 0, 3), 3'd7, lat);
        assert (ar_count == ar0 + 1) else begin errors++; $display("Read miss gave no single burst"); end
        for (int i = 0; i < 5; i++) check_read(make_addr(1, 0, i), sizes[i], lat);
        finish_test("read_miss");

        ar0 = ar_count;
        aw0 = aw_count;
        check_read(make_addr(1, 0, 5), 3'd4, lat);
        assert (lat == 2) else report_mismatch("hit_latency", word_t'(2), word_t'(lat));
        assert (ar_count == ar0 && aw_count == aw0)
            else begin errors++; $display("Read hit caused bus traffic"); end
        finish_test("read_hit_timing");

        do_write(make_addr(1, 0, 2), 3'd2, 64'h1122_3344_5566_7788);
        do_write(make_addr(2, 0, 6), 3'd4, 64'hCAFE_F00D_DEAD_BEEF);
        check_read(make_addr(1, 0, 2), 3'd7, lat);
        check_read(make_addr(2, 0, 6), 3'd7, lat);
        finish_test("stores");

        aw0 = aw_count;
        check_read(make_addr(3, 0, 1), 3'd7, lat);
        assert (aw_count == aw0 + 1) else begin errors++; $display("Dirty victim not written back"); end
        compare_line(make_addr(1, 0, 0));
        check_read(make_addr(1, 0, 2), 3'd7, lat);
        finish_test("dirty_eviction");

        #1 stall = 1'b1;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            set = $random(seed) & 1;
            tag = set ? 4 + ($random(seed) & 1) : 1 + ({$random(seed)} % 3);
            rand_addr = make_addr(tag, set, $random(seed) & 7);
            if ($random(seed) & 1) do_write(rand_addr, sizes[{$random(seed)} % 5],
                                            {$random(seed), $random(seed)});
            else check_read(rand_addr, sizes[{$random(seed)} % 5], lat);
        end
        finish_test("back_pressure");

        $display("tests %0d, cycles %0d, errors %0d", tests, cycles,
                 errors + mem_model_i.error_count);
        if (errors + mem_model_i.error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/axi_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

// Memory slave for line bursts, 4 KB window starting at address 0
module axi_mem_model (
    input  logic        clock,
    input  logic        reset,
    input  logic        stall,          // Enables random back-pressure
    input  logic        arvalid,
    input  logic [63:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    output logic        arready,
    output logic        rvalid,
    output logic        rlast,
    output logic [63:0] rdata,
    input  logic        rready,
    input  logic        awvalid,
    input  logic [63:0] awaddr,
    input  logic [7:0]  awlen,
    input  logic [2:0]  awsize,
    input  logic [1:0]  awburst,
    output logic        awready,
    input  logic [63:0] wdata,
    input  logic [7:0]  wstrb,
    input  logic        wvalid,
    input  logic        wlast,
    output logic        wready,
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready
);

    logic [63:0] mem [512];
    int          error_count = 0;
    integer      seed = 38;

    logic       rd_active = 1'b0, r_hold = 1'b0, wr_active = 1'b0;
    logic       b_pend = 1'b0, b_hold = 1'b0;
    logic       ar_rdy = 1'b0, aw_rdy = 1'b0, w_rdy = 1'b0;
    logic [8:0] rd_idx = '0, wr_idx = '0;
    logic [2:0] rd_cnt = '0, w_cnt = '0;

    initial begin
        for (int i = 0; i < 512; i++) begin
            mem[i] = (64'(i) << 3) ^ 64'h5A5A_5A5A_5A5A_5A5A;
        end
    end

    // One stall in four while back-pressure is on
    function automatic logic stall_now();
        return stall && (($random(seed) & 3) == 0);
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            rd_active <= 1'b0;
            r_hold    <= 1'b0;
            wr_active <= 1'b0;
            b_pend    <= 1'b0;
            b_hold    <= 1'b0;
            ar_rdy    <= 1'b0;
            aw_rdy    <= 1'b0;
            w_rdy     <= 1'b0;
        end else begin
            ar_rdy <= !stall_now();
            aw_rdy <= !stall_now();
            w_rdy  <= !stall_now();
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_idx    <= araddr[11:3];
                rd_cnt    <= '0;
                r_hold    <= stall_now();
            end else if (rvalid && rready) begin
                rd_cnt <= rd_cnt + 1'b1;
                r_hold <= stall_now();
                if (rlast) rd_active <= 1'b0;
            end else if (r_hold) begin
                r_hold <= stall_now();   // A raised rvalid is never withdrawn
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_idx    <= awaddr[11:3];
                w_cnt     <= '0;
            end
            if (wvalid && wready) begin
                mem[wr_idx + {6'b0, w_cnt}] <= wdata;
                w_cnt <= w_cnt + 1'b1;
                if (w_cnt == 3'd7) begin
                    wr_active <= 1'b0;
                    b_pend    <= 1'b1;
                    b_hold    <= stall_now();
                end
            end
            if (bvalid && bready) b_pend <= 1'b0;
            else if (b_hold) b_hold <= stall_now();
        end
    end

    assign arready = ar_rdy && !rd_active;
    assign rvalid  = rd_active && !r_hold;
    assign rdata   = mem[rd_idx + {6'b0, rd_cnt}];
    assign rlast   = (rd_cnt == 3'd7);
    assign awready = aw_rdy && !wr_active && !b_pend;
    assign wready  = wr_active && w_rdy;
    assign bvalid  = b_pend && !b_hold;
    assign bresp   = 2'b00;

    a_ar_format: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> (arlen == 8'd7 && arsize == 3'd3 && arburst == 2'd1 && araddr[5:0] == 0))
        else begin error_count++; $display("read burst fields wrong at %0t", $time); end
    a_aw_format: assert property (@(posedge clock) disable iff (reset)
        awvalid |-> (awlen == 8'd7 && awsize == 3'd3 && awburst == 2'd1 && awaddr[5:0] == 0))
        else begin error_count++; $display("write burst fields wrong at %0t", $time); end
    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin error_count++; $display("arvalid dropped before handshake at %0t", $time); end
    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin error_count++; $display("awvalid dropped before handshake at %0t", $time); end
    a_w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin error_count++; $display("wvalid dropped before handshake at %0t", $time); end
    a_w_strb: assert property (@(posedge clock) disable iff (reset)
        wvalid |-> (wstrb == 8'hFF))
        else begin error_count++; $display("write strobes not all set at %0t", $time); end
    // wlast only on the eighth beat
    a_w_last: assert property (@(posedge clock) disable iff (reset)
        wvalid |-> (wlast == (w_cnt == 3'd7)))
        else begin error_count++; $display("wlast on wrong beat at %0t", $time); end

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         read_enable,    // Held until send_enable
    input  logic                         write_enable,
    input  addr_t                        address,
    input  size_t                        data_size,
    input  word_t                        data_input,

    input  logic                         m_axi_arready,
    input  logic                         m_axi_rvalid,
    input  logic                         m_axi_rlast,
    input  word_t                        m_axi_rdata,
    output logic                         m_axi_arvalid,
    output addr_t                        m_axi_araddr,
    output logic [`DC_LEN_WIDTH-1:0]     m_axi_arlen,
    output logic [`DC_AXSIZE_WIDTH-1:0]  m_axi_arsize,
    output logic [`DC_BURST_WIDTH-1:0]   m_axi_arburst,
    output logic                         m_axi_rready,

    input  logic                         m_axi_awready,
    input  logic                         m_axi_wready,
    input  logic                         m_axi_bvalid,
    input  logic [1:0]                   m_axi_bresp,
    output logic                         m_axi_awvalid,
    output addr_t                        m_axi_awaddr,
    output logic [`DC_LEN_WIDTH-1:0]     m_axi_awlen,
    output logic [`DC_AXSIZE_WIDTH-1:0]  m_axi_awsize,
    output logic [`DC_BURST_WIDTH-1:0]   m_axi_awburst,
    output word_t                        m_axi_wdata,
    output logic [`DC_STRB_WIDTH-1:0]    m_axi_wstrb,
    output logic                         m_axi_wvalid,
    output logic                         m_axi_wlast,
    output logic                         m_axi_bready,

    output word_t                        data,
    output logic                         send_enable
);

    cpu_req_t  req;
    lookup_t   lookup;
    axi_addr_t ar, aw;
    beat_t     beat;
    logic      last_beat, beat_clear, beat_step;
    logic      fill_tag, fill_beat, mark_dirty, store_word;
    way_t      active_way;

    assign req = '{read: read_enable, write: write_enable, address: address,
                   size: data_size, wdata: data_input};

    dcache_ctrl dcache_ctrl_i (
        .clock, .reset, .req, .lookup, .beat, .last_beat,
        .arready(m_axi_arready), .rvalid(m_axi_rvalid), .rlast(m_axi_rlast),
        .awready(m_axi_awready), .wready(m_axi_wready), .bvalid(m_axi_bvalid),
        .ar, .aw, .rready(m_axi_rready), .wvalid(m_axi_wvalid), .wlast(m_axi_wlast),
        .bready(m_axi_bready), .beat_clear, .beat_step, .fill_tag, .fill_beat,
        .mark_dirty, .store_word, .active_way, .send_enable
    );

    beat_counter beat_counter_i (
        .clock, .reset, .clear(beat_clear), .step(beat_step), .beat, .last_beat
    );

    tag_store tag_store_i (
        .clock, .reset, .req, .active_way, .fill_tag, .mark_dirty, .lookup
    );

    line_store line_store_i (
        .clock, .req, .active_way, .beat, .fill_beat, .fill_data(m_axi_rdata),
        .store_word, .read_data(data), .wb_data(m_axi_wdata)
    );

    // Address channels unpacked onto the bus
    assign m_axi_arvalid = ar.valid;
    assign m_axi_araddr  = ar.addr;
    assign m_axi_arlen   = ar.len;
    assign m_axi_arsize  = ar.size;
    assign m_axi_arburst = ar.burst;
    assign m_axi_awvalid = aw.valid;
    assign m_axi_awaddr  = aw.addr;
    assign m_axi_awlen   = aw.len;
    assign m_axi_awsize  = aw.size;
    assign m_axi_awburst = aw.burst;
    assign m_axi_wstrb   = '1;    // Whole lines only

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  cpu_req_t  req,
    input  lookup_t   lookup,
    input  beat_t     beat,
    input  logic      last_beat,
    input  logic      arready,
    input  logic      rvalid,
    input  logic      rlast,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,
    output axi_addr_t ar,
    output axi_addr_t aw,
    output logic      rready,
    output logic      wvalid,
    output logic      wlast,
    output logic      bready,
    output logic      beat_clear,
    output logic      beat_step,
    output logic      fill_tag,
    output logic      fill_beat,
    output logic      mark_dirty,
    output logic      store_word,
    output way_t      active_way,
    output logic      send_enable
);

    ctrl_state_t state, state_next;
    tag_t        evict_tag;     // Victim tag kept for the write-back address
    index_t      index;

    assign index = req.address[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            active_way <= '0;
        end else begin
            state <= state_next;
            if (state == LOOKUP) begin
                active_way <= lookup.hit ? lookup.hit_way : lookup.victim_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == LOOKUP) evict_tag <= lookup.victim_tag;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:        if (req.read || req.write) state_next = LOOKUP;
            LOOKUP: begin
                if (lookup.hit) begin
                    state_next = RESPOND;
                end else if (lookup.victim_valid && lookup.victim_dirty) begin
                    state_next = EVICT_ADDR;   // Write back before refill
                end else begin
                    state_next = REFILL_ADDR;
                end
            end
            EVICT_ADDR:  if (awready) state_next = EVICT_DATA;
            EVICT_DATA:  if (wready && last_beat) state_next = EVICT_RESP;
            EVICT_RESP:  if (bvalid) state_next = REFILL_ADDR;   // bresp ignored
            REFILL_ADDR: if (arready) state_next = REFILL_DATA;
            REFILL_DATA: if (rvalid && rlast) state_next = RESPOND;
            RESPOND:     state_next = RELEASE;
            RELEASE:     if (!req.read && !req.write) state_next = IDLE;
            default:     state_next = IDLE;
        endcase
    end

    // Line-aligned burst addresses
    always_comb begin
        ar.valid = (state == REFILL_ADDR);
        ar.addr  = {req.address[`DC_ADDR_WIDTH-1:`DC_OFFSET_WIDTH], {`DC_OFFSET_WIDTH{1'b0}}};
        ar.len   = `DC_BURST_LEN;
        ar.size  = `DC_BEAT_SIZE;
        ar.burst = `DC_BURST_INCR;

        aw.valid = (state == EVICT_ADDR);
        aw.addr  = {evict_tag, index, {`DC_OFFSET_WIDTH{1'b0}}};
        aw.len   = `DC_BURST_LEN;
        aw.size  = `DC_BEAT_SIZE;
        aw.burst = `DC_BURST_INCR;
    end

    assign rready = (state == REFILL_DATA);
    assign wvalid = (state == EVICT_DATA);
    assign wlast  = wvalid && last_beat;
    assign bready = (state == EVICT_RESP);

    // Counter restarts while an address phase is pending
    assign beat_clear = (state == EVICT_ADDR) || (state == REFILL_ADDR);
    assign fill_beat  = rready && rvalid;
    assign beat_step  = fill_beat || (wvalid && wready);
    assign fill_tag   = fill_beat && rlast;   // Tag goes in with the last beat

    assign send_enable = (state == RESPOND);
    assign store_word  = send_enable && req.write;
    assign mark_dirty  = store_word;

    a_send_pulse: assert property (@(posedge clock) disable iff (reset)
        send_enable |=> !send_enable);

    a_one_addr_channel: assert property (@(posedge clock) disable iff (reset)
        !(ar.valid && aw.valid));

    // Memory side must end the refill on the eighth beat
    a_rlast_on_beat7: assert property (@(posedge clock) disable iff (reset)
        fill_tag |-> (beat == beat_t'(`DC_BURST_LEN)));

endmodule

`default_nettype wire

// ==== src/line_store.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module line_store
    import dcache_pkg::*;
(
    input  logic     clock,
    input  cpu_req_t req,
    input  way_t     active_way,
    input  beat_t    beat,
    input  logic     fill_beat,
    input  word_t    fill_data,
    input  logic     store_word,
    output word_t    read_data,
    output word_t    wb_data
);

    line_t  lines [`DC_SETS][`DC_WAYS];

    index_t index;
    beat_t  word_sel;
    word_t  mask;
    word_t  cur_word;
    word_t  merged;

    assign index    = req.address[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
    assign word_sel = req.address[`DC_OFFSET_WIDTH-1:`DC_WORD_LSB];

    // Low bytes selected by the size code
    always_comb begin
        case (req.size)
            3'd1:    mask = 64'h0000_0000_0000_00FF;
            3'd2:    mask = 64'h0000_0000_0000_FFFF;
            3'd4:    mask = 64'h0000_0000_FFFF_FFFF;
            3'd7:    mask = 64'hFFFF_FFFF_FFFF_FFFF;
            default: mask = 64'h0;   // Unknown size reads zero, writes nothing
        endcase
    end

    assign cur_word = lines[index][active_way][word_sel*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];
    assign merged   = (cur_word & ~mask) | (req.wdata & mask);

    assign read_data = cur_word & mask;   // Zero-extended by the mask
    assign wb_data   = lines[index][active_way][beat*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];

    // Refill beats and CPU stores share one write port
    always_ff @(posedge clock) begin
        if (fill_beat) begin
            lines[index][active_way][beat*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] <= fill_data;
        end else if (store_word) begin
            lines[index][active_way][word_sel*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] <= merged;
        end
    end

    // A store only follows a completed refill
    a_port_exclusive: assert property (@(posedge clock)
        !(fill_beat && store_word));

endmodule

`default_nettype wire

// ==== src/tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

module tag_store
    import dcache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  cpu_req_t req,
    input  way_t     active_way,
    input  logic     fill_tag,
    input  logic     mark_dirty,
    output lookup_t  lookup
);

    tag_t                tags  [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0] valid [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty [`DC_SETS];
    way_t                rr_ptr;      // Shared round-robin victim pointer

    index_t              index;
    tag_t                tag;
    logic [`DC_WAYS-1:0] way_hit;
    way_t                hit_way;
    way_t                victim_way;

    assign index = req.address[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
    assign tag   = req.address[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid[index][w] && (tags[index][w] == tag);
        end
    end

    // Scan downwards so the lowest matching or invalid way wins
    always_comb begin
        hit_way    = '0;
        victim_way = rr_ptr;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) hit_way = way_t'(w);
            if (!valid[index][w]) victim_way = way_t'(w);
        end
    end

    assign lookup = '{hit:          |way_hit,
                      hit_way:      hit_way,
                      victim_way:   victim_way,
                      victim_valid: valid[index][victim_way],
                      victim_dirty: dirty[index][victim_way],
                      victim_tag:   tags[index][victim_way]};

    always_ff @(posedge clock) begin
        if (fill_tag) tags[index][active_way] <= tag;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            rr_ptr <= '0;
        end else if (fill_tag) begin
            valid[index][active_way] <= 1'b1;
            dirty[index][active_way] <= 1'b0;     // Fresh line from memory
            if (valid[index][active_way]) begin
                rr_ptr <= rr_ptr + 1'b1;          // A resident line was replaced
            end
        end else if (mark_dirty) begin
            dirty[index][active_way] <= 1'b1;
        end
    end

    // The controller must never install a tag that is already resident
    a_single_hit: assert property (@(posedge clock) disable iff (reset)
        $onehot0(way_hit));

endmodule

`default_nettype wire

// ==== src/beat_counter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dcache_consts.svh"

// Beat position inside one line burst
module beat_counter
    import dcache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  clear,
    input  logic  step,
    output beat_t beat,
    output logic  last_beat
);

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            beat <= '0;
        end else if (step) begin
            beat <= beat + 1'b1;   // Wraps after the last beat
        end
    end

    assign last_beat = (beat == beat_t'(`DC_LINE_BEATS - 1));

endmodule

`default_nettype wire

// ==== src/dcache_pkg.sv ====
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_WIDTH-1:0]                  addr_t;
    typedef logic [`DC_DATA_WIDTH-1:0]                  word_t;
    typedef logic [`DC_LINE_BEATS*`DC_DATA_WIDTH-1:0]   line_t;
    typedef logic [`DC_TAG_WIDTH-1:0]                   tag_t;
    typedef logic [`DC_INDEX_WIDTH-1:0]                 index_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]                way_t;
    typedef logic [$clog2(`DC_LINE_BEATS)-1:0]          beat_t;
    typedef logic [2:0]                                 size_t;   // 1, 2, 4 or 7

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        EVICT_ADDR,
        EVICT_DATA,
        EVICT_RESP,
        REFILL_ADDR,
        REFILL_DATA,
        RESPOND,
        RELEASE
    } ctrl_state_t;

    // CPU request as held by the core
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        size_t size;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_valid;
        logic victim_dirty;
        tag_t victim_tag;    // Tag of the line that may be written back
    } lookup_t;

    typedef struct packed {
        logic                         valid;
        addr_t                        addr;
        logic [`DC_LEN_WIDTH-1:0]     len;
        logic [`DC_AXSIZE_WIDTH-1:0]  size;
        logic [`DC_BURST_WIDTH-1:0]   burst;
    } axi_addr_t;

endpackage

`default_nettype wire

// ==== src/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Bus widths
`define DC_ADDR_WIDTH    64
`define DC_DATA_WIDTH    64
`define DC_STRB_WIDTH    8

// Cache geometry
`define DC_SETS          2
`define DC_WAYS          2
`define DC_LINE_BEATS    8
`define DC_WORD_LSB      3      // Byte offset bits inside one word
`define DC_OFFSET_WIDTH  6
`define DC_INDEX_WIDTH   1
`define DC_TAG_WIDTH     (`DC_ADDR_WIDTH - `DC_OFFSET_WIDTH - `DC_INDEX_WIDTH)

// Burst fields of the address channels
`define DC_LEN_WIDTH     8
`define DC_AXSIZE_WIDTH  3
`define DC_BURST_WIDTH   2
`define DC_BURST_LEN     8'd7   // Eight beats per line
`define DC_BEAT_SIZE     3'd3   // 8 bytes per beat
`define DC_BURST_INCR    2'd1

`endif
